//--- hw/fetch_cfg_pkg.sv
// Configuration package for the instruction fetch read merger
// Field widths, order queue depth, vector typedefs
// and the requester source enum shared by grant state and queue entries

`default_nettype none

package fetch_cfg_pkg;

	localparam int ADDR_W      = 32;
	localparam int DATA_W      = 32;
	localparam int ID_W        = 4;
	localparam int LEN_W       = 8;
	localparam int SIZE_W      = 3;
	localparam int BURST_W     = 2;
	localparam int RESP_W      = 2;

	localparam int ORDER_DEPTH = 3; // Outstanding bursts on the memory port
	localparam int ORDER_PTR_W = $clog2(ORDER_DEPTH);
	localparam int ORDER_CNT_W = $clog2(ORDER_DEPTH + 1);

	typedef logic [ADDR_W-1:0]  addr_t;
	typedef logic [DATA_W-1:0]  data_t;
	typedef logic [ID_W-1:0]    axi_id_t;
	typedef logic [LEN_W-1:0]   burst_len_t; // Beats minus one
	typedef logic [SIZE_W-1:0]  beat_size_t;
	typedef logic [BURST_W-1:0] burst_kind_t;
	typedef logic [RESP_W-1:0]  resp_t;

	typedef enum logic {src_uncached = 1'b0, src_cached = 1'b1} fetch_src_t;

endpackage

`default_nettype wire

//--- hw/fetch_bus_pkg.sv
// Channel package for the instruction fetch read merger
// Read address request struct
// Read data beat struct

`default_nettype none

package fetch_bus_pkg;

	//////////////////////////////////////////////////////////////////////
	// Read address channel
	//////////////////////////////////////////////////////////////////////

	// Fields are held steady by the master until valid meets ready
	typedef struct packed {
		logic                         valid;
		fetch_cfg_pkg::addr_t         addr;
		fetch_cfg_pkg::burst_len_t    len;   // Beats minus one
		fetch_cfg_pkg::beat_size_t    size;
		fetch_cfg_pkg::burst_kind_t   burst;
		fetch_cfg_pkg::axi_id_t       id;
	} ar_req_t;

	//////////////////////////////////////////////////////////////////////
	// Read data channel
	//////////////////////////////////////////////////////////////////////

	// One beat of a burst, last marks the final beat
	typedef struct packed {
		logic                         valid;
		fetch_cfg_pkg::data_t         data;
		fetch_cfg_pkg::resp_t         resp;
		fetch_cfg_pkg::axi_id_t       id;
		logic                         last;
	} rd_beat_t;

endpackage

`default_nettype wire

//--- hw/read_arbiter.sv
// Read address arbiter for two fetch requesters
// Grant state machine with hold-until-idle switching
// Address channel mux, valid and ready gating by order queue full
// Push report of every accepted address to the order queue

`timescale 1ns/1ps
`default_nettype none

module read_arbiter
(
	input  wire                        clk,
	input  wire                        rstnn,

	input  wire fetch_bus_pkg::ar_req_t uc_ar,
	output logic                       uc_ar_ready,
	input  wire fetch_bus_pkg::ar_req_t c_ar,
	output logic                       c_ar_ready,

	output fetch_bus_pkg::ar_req_t     mem_ar,
	input  wire                        mem_ar_ready,

	input  wire                        full,
	output logic                       push,
	output fetch_cfg_pkg::fetch_src_t  push_src
);

	//////////////////////////////////////////////////////////////////////
	// Signals
	//////////////////////////////////////////////////////////////////////

	fetch_cfg_pkg::fetch_src_t grant;
	fetch_bus_pkg::ar_req_t    sel_ar;
	logic                      uc_granted;
	logic                      ar_open;

	//////////////////////////////////////////////////////////////////////
	// Grant state
	//////////////////////////////////////////////////////////////////////

	// Grant leaves a source only once it drops valid and the other waits
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			grant <= fetch_cfg_pkg::src_uncached;
		end
		else
		begin
			case (grant)
				fetch_cfg_pkg::src_uncached:
				begin
					if (!uc_ar.valid && c_ar.valid)
						grant <= fetch_cfg_pkg::src_cached;
				end
				fetch_cfg_pkg::src_cached:
				begin
					if (!c_ar.valid && uc_ar.valid)
						grant <= fetch_cfg_pkg::src_uncached;
				end
				default:
				begin
					grant <= fetch_cfg_pkg::src_uncached;
				end
			endcase
		end
	end

	assign uc_granted = (grant == fetch_cfg_pkg::src_uncached);

	// No new address while the order queue has no room
	assign ar_open = rstnn & ~full;

	//////////////////////////////////////////////////////////////////////
	// Address channel
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		sel_ar = uc_granted ? uc_ar : c_ar;
		mem_ar = sel_ar;
		mem_ar.valid = sel_ar.valid & ar_open;
	end

	assign uc_ar_ready = uc_granted & mem_ar_ready & ar_open;
	assign c_ar_ready  = ~uc_granted & mem_ar_ready & ar_open; // Loser sees ready low

	// Accepted address goes to the queue in the same cycle
	assign push     = mem_ar.valid & mem_ar_ready;
	assign push_src = grant;

endmodule

`default_nettype wire

//--- hw/response_order_queue.sv
// Response order queue for the fetch read merger
// Small FIFO of requester sources in address acceptance order
// Read data and ready steering by the queue head
// Head pop on the last beat of each burst

`timescale 1ns/1ps
`default_nettype none

module response_order_queue
(
	input  wire                          clk,
	input  wire                          rstnn,

	input  wire                          push,
	input  wire fetch_cfg_pkg::fetch_src_t push_src,
	output logic                         full,

	input  wire fetch_bus_pkg::rd_beat_t mem_r,
	output logic                         mem_r_ready,

	output fetch_bus_pkg::rd_beat_t      uc_r,
	input  wire                          uc_r_ready,
	output fetch_bus_pkg::rd_beat_t      c_r,
	input  wire                          c_r_ready
);

	//////////////////////////////////////////////////////////////////////
	// Signals
	//////////////////////////////////////////////////////////////////////

	fetch_cfg_pkg::fetch_src_t entry [fetch_cfg_pkg::ORDER_DEPTH];

	logic [fetch_cfg_pkg::ORDER_PTR_W-1:0] wr_ptr;
	logic [fetch_cfg_pkg::ORDER_PTR_W-1:0] rd_ptr;
	logic [fetch_cfg_pkg::ORDER_CNT_W-1:0] count;

	fetch_cfg_pkg::fetch_src_t head;
	logic                      empty;
	logic                      pop;

	localparam logic [fetch_cfg_pkg::ORDER_PTR_W-1:0] LAST_PTR =
		fetch_cfg_pkg::ORDER_PTR_W'(fetch_cfg_pkg::ORDER_DEPTH - 1);

	//////////////////////////////////////////////////////////////////////
	// Order FIFO
	//////////////////////////////////////////////////////////////////////

	assign empty = (count == '0);
	assign full  = (count == fetch_cfg_pkg::ORDER_CNT_W'(fetch_cfg_pkg::ORDER_DEPTH));
	assign head  = entry[rd_ptr];
	assign pop   = mem_r.valid & mem_r_ready & mem_r.last;

	always_ff @(posedge clk)
	begin
		if (push)
			entry[wr_ptr] <= push_src;
	end

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Data steering
	//////////////////////////////////////////////////////////////////////

	// Payload fans out to both, only the head requester sees valid
	always_comb
	begin
		uc_r = mem_r;
		c_r  = mem_r;
		uc_r.valid = mem_r.valid & ~empty & (head == fetch_cfg_pkg::src_uncached);
		c_r.valid  = mem_r.valid & ~empty & (head == fetch_cfg_pkg::src_cached);
		if (empty)
			mem_r_ready = 1'b0;
		else if (head == fetch_cfg_pkg::src_uncached)
			mem_r_ready = uc_r_ready;
		else
			mem_r_ready = c_r_ready;
	end

endmodule

`default_nettype wire

//--- hw/fetch_merge_top.sv
// Top level of the instruction fetch read merger
// Two requester read ports merged onto one memory read port
// Arbiter on the address side, order queue on the data side

`timescale 1ns/1ps
`default_nettype none

module fetch_merge_top
(
	input  wire                          clk,
	input  wire                          rstnn,

	// Uncached requester
	input  wire fetch_bus_pkg::ar_req_t  uc_ar,
	output logic                         uc_ar_ready,
	output fetch_bus_pkg::rd_beat_t      uc_r,
	input  wire                          uc_r_ready,

	// Cached line fill requester
	input  wire fetch_bus_pkg::ar_req_t  c_ar,
	output logic                         c_ar_ready,
	output fetch_bus_pkg::rd_beat_t      c_r,
	input  wire                          c_r_ready,

	// Memory side
	output fetch_bus_pkg::ar_req_t       mem_ar,
	input  wire                          mem_ar_ready,
	input  wire fetch_bus_pkg::rd_beat_t mem_r,
	output logic                         mem_r_ready
);

	//////////////////////////////////////////////////////////////////////
	// Arbiter to queue
	//////////////////////////////////////////////////////////////////////

	logic                      push;
	fetch_cfg_pkg::fetch_src_t push_src;
	logic                      full;

	read_arbiter u_arbiter
	(
		.clk          (clk),
		.rstnn        (rstnn),
		.uc_ar        (uc_ar),
		.uc_ar_ready  (uc_ar_ready),
		.c_ar         (c_ar),
		.c_ar_ready   (c_ar_ready),
		.mem_ar       (mem_ar),
		.mem_ar_ready (mem_ar_ready),
		.full         (full),
		.push         (push),
		.push_src     (push_src)
	);

	// Bursts come back in address order, so the queue head owns mem_r
	response_order_queue u_order
	(
		.clk          (clk),
		.rstnn        (rstnn),
		.push         (push),
		.push_src     (push_src),
		.full         (full),
		.mem_r        (mem_r),
		.mem_r_ready  (mem_r_ready),
		.uc_r         (uc_r),
		.uc_r_ready   (uc_r_ready),
		.c_r          (c_r),
		.c_r_ready    (c_r_ready)
	);

endmodule

`default_nettype wire

//--- bench/fetch_merge_asserts.sv
// Protocol assertions for the fetch read merger
// Single response owner, no pop from an empty order queue
// Stable address request while stalled, bound to the top level

`timescale 1ns/1ps
`default_nettype none

module fetch_merge_asserts
(
	input wire                          clk,
	input wire                          rstnn,
	input wire fetch_bus_pkg::ar_req_t  mem_ar,
	input wire                          mem_ar_ready,
	input wire fetch_bus_pkg::rd_beat_t mem_r,
	input wire                          mem_r_ready,
	input wire fetch_bus_pkg::rd_beat_t uc_r,
	input wire fetch_bus_pkg::rd_beat_t c_r
);

	int assert_failures = 0;

	logic [fetch_cfg_pkg::ORDER_CNT_W-1:0] outstanding; // Bursts open on the memory port
	logic                                  ar_fire;
	logic                                  r_done;

	assign ar_fire = mem_ar.valid & mem_ar_ready;
	assign r_done  = mem_r.valid & mem_r_ready & mem_r.last;

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			outstanding <= '0;
		else if (ar_fire && !r_done)
			outstanding <= outstanding + 1'b1;
		else if (r_done && !ar_fire)
			outstanding <= outstanding - 1'b1;
	end

	// A beat reaches exactly one requester while bursts are open, none otherwise
	a_single_owner: assert property (@(posedge clk) disable iff (!rstnn)
		!(uc_r.valid && c_r.valid) &&
		((uc_r.valid || c_r.valid) == (mem_r.valid && outstanding != '0)))
	else
	begin
		assert_failures++;
		$error("uc_r and c_r valid do not match a single open burst owner");
	end

	a_no_empty_pop: assert property (@(posedge clk) disable iff (!rstnn)
		r_done |-> (outstanding != '0))
	else
	begin
		assert_failures++;
		$error("order queue popped while empty");
	end

	a_ar_stable: assert property (@(posedge clk) disable iff (!rstnn)
		(mem_ar.valid && !mem_ar_ready) |=> $stable(mem_ar))
	else
	begin
		assert_failures++;
		$error("mem_ar changed while stalled");
	end

endmodule

bind fetch_merge_top fetch_merge_asserts u_asserts
(
	.clk          (clk),
	.rstnn        (rstnn),
	.mem_ar       (mem_ar),
	.mem_ar_ready (mem_ar_ready),
	.mem_r        (mem_r),
	.mem_r_ready  (mem_r_ready),
	.uc_r         (uc_r),
	.c_r          (c_r)
);

`default_nettype wire

//--- bench/fetch_merge_tb.sv
// Testbench for the fetch read merger
// Requester and memory models, reference data function
// Beat checker, watchdog and per-test report

`timescale 1ns/1ps
`default_nettype none

module fetch_merge_tb;

	localparam int CLK_PERIOD      = 10;
	localparam int RESET_CYCLES    = 8;
	localparam int SINGLE_BURSTS   = 12;
	localparam int MIXED_BURSTS    = 20;
	localparam int HOLD_BURSTS     = 6;
	localparam int LIMIT_BURSTS    = 5;
	localparam int PLANNED_BURSTS  =
		2 * SINGLE_BURSTS + 2 * MIXED_BURSTS + 2 * HOLD_BURSTS + LIMIT_BURSTS + 1;
	localparam int PLANNED_BEATS   = PLANNED_BURSTS * 4; // At most 4 beats per burst
	localparam int WATCHDOG_CYCLES = PLANNED_BEATS * 40 + 2000;
	localparam logic [31:0] DATA_KEY = 32'h5A3C_96E1;

	typedef struct packed {
		fetch_cfg_pkg::addr_t      addr;
		fetch_cfg_pkg::burst_len_t len;
		fetch_cfg_pkg::axi_id_t    id;
	} burst_t;

	logic                    clk;
	logic                    rstnn;
	fetch_bus_pkg::ar_req_t  uc_ar;
	fetch_bus_pkg::ar_req_t  c_ar;
	fetch_bus_pkg::ar_req_t  mem_ar;
	fetch_bus_pkg::rd_beat_t uc_r;
	fetch_bus_pkg::rd_beat_t c_r;
	fetch_bus_pkg::rd_beat_t mem_r;
	logic                    uc_ar_ready;
	logic                    c_ar_ready;
	logic                    uc_r_ready;
	logic                    c_r_ready;
	logic                    mem_ar_ready;
	logic                    mem_r_ready;

	int     errors;
	int     checks;
	int     test_num;
	int     tests_failed;
	int     test_err_base;
	int     uc_todo;
	int     c_todo;
	int     uc_seq;
	int     c_seq;
	int     issue_pct;
	int     uc_rdy_pct;
	int     c_rdy_pct;
	int     mem_ar_pct;
	int     mem_r_pct;
	int     uc_beat;
	int     c_beat;
	int     mem_beat;
	int     mem_ar_count;
	int     mem_done_count;
	bit     uc_fired;
	bit     c_fired;
	bit     mem_r_fired;
	bit     mem_hold;
	bit     mem_one_shot;
	bit     hold_check;
	burst_t uc_exp[$];
	burst_t c_exp[$];
	burst_t mem_q[$]; // Accepted by memory, in order

	fetch_merge_top dut
	(
		.clk          (clk),
		.rstnn        (rstnn),
		.uc_ar        (uc_ar),
		.uc_ar_ready  (uc_ar_ready),
		.uc_r         (uc_r),
		.uc_r_ready   (uc_r_ready),
		.c_ar         (c_ar),
		.c_ar_ready   (c_ar_ready),
		.c_r          (c_r),
		.c_r_ready    (c_r_ready),
		.mem_ar       (mem_ar),
		.mem_ar_ready (mem_ar_ready),
		.mem_r        (mem_r),
		.mem_r_ready  (mem_r_ready)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Reference and helpers
	//////////////////////////////////////////////////////////////////////

	// Word at beat n of a burst starting at addr
	function automatic fetch_cfg_pkg::data_t expected_word(input fetch_cfg_pkg::addr_t addr,
		input int beat);
		return (addr + 32'(4 * beat)) ^ DATA_KEY;
	endfunction

	function automatic fetch_bus_pkg::ar_req_t make_request(input logic src, input int seq);
		fetch_bus_pkg::ar_req_t req;
		req.valid = 1'b1;
		req.addr  = $urandom() & 32'hFFFF_FFFC;
		req.len   = 8'($urandom_range(3, 0));
		req.size  = 3'd2;
		req.burst = 2'b01; // Incrementing
		req.id    = {src, 3'(seq)};
		return req;
	endfunction

	function automatic burst_t burst_of(input fetch_bus_pkg::ar_req_t req);
		return '{addr: req.addr, len: req.len, id: req.id};
	endfunction

	function automatic int total_errors();
		return errors + dut.u_asserts.assert_failures;
	endfunction

	task automatic report_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		errors++;
	endtask

	task automatic report_failure(input string msg);
		$display("Failure at %0d ns: %s", $time, msg);
		errors++;
	endtask

	task automatic check_beat(input string who, input fetch_bus_pkg::rd_beat_t got,
		input burst_t exp, input int beat);
		checks++;
		if (got.data !== expected_word(exp.addr, beat))
			report_value({who, ".data"}, got.data, expected_word(exp.addr, beat));
		if (got.id !== exp.id)
			report_value({who, ".id"}, got.id, exp.id);
		if (got.last !== (beat == int'(exp.len)))
			report_value({who, ".last"}, got.last, beat == int'(exp.len));
		if (got.resp !== '0)
			report_value({who, ".resp"}, got.resp, 0);
	endtask

	task automatic check_idle_outputs();
		if (mem_ar.valid !== 1'b0)
			report_value("mem_ar.valid", mem_ar.valid, 0);
		if (uc_ar_ready !== 1'b0)
			report_value("uc_ar_ready", uc_ar_ready, 0);
		if (c_ar_ready !== 1'b0)
			report_value("c_ar_ready", c_ar_ready, 0);
		if (uc_r.valid !== 1'b0)
			report_value("uc_r.valid", uc_r.valid, 0);
		if (c_r.valid !== 1'b0)
			report_value("c_r.valid", c_r.valid, 0);
	endtask

	// Queue full, so the waiting uncached request must stay blocked
	task automatic check_blocked();
		if (uc_ar.valid !== 1'b1)
			report_failure("uncached requester stopped requesting while the queue was full");
		if (mem_ar.valid !== 1'b0)
			report_value("mem_ar.valid", mem_ar.valid, 0);
		if (uc_ar_ready !== 1'b0)
			report_value("uc_ar_ready", uc_ar_ready, 0);
	endtask

	task automatic wait_idle();
		@(negedge clk);
		while (uc_todo > 0 || c_todo > 0 || uc_ar.valid || c_ar.valid ||
			uc_exp.size() > 0 || c_exp.size() > 0 || mem_q.size() > 0)
			@(negedge clk);
	endtask

	task automatic end_test(input string name);
		int test_errors;
		test_errors = total_errors() - test_err_base;
		test_num++;
		if (test_errors == 0)
			$display("Test %0d %s: passed", test_num, name);
		else
		begin
			$display("Test %0d %s: failed with %0d errors", test_num, name, test_errors);
			tests_failed++;
		end
		test_err_base = total_errors();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Requester and memory models, driven on the falling edge
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		if (uc_fired || !uc_ar.valid)
		begin
			uc_fired = 1'b0;
			if (uc_todo > 0 && int'($urandom_range(99)) < issue_pct)
			begin
				uc_ar = make_request(1'b0, uc_seq);
				uc_seq++;
				uc_todo--;
			end
			else
				uc_ar = '0;
		end
		uc_r_ready = (int'($urandom_range(99)) < uc_rdy_pct);
	end

	always @(negedge clk)
	begin
		if (c_fired || !c_ar.valid)
		begin
			c_fired = 1'b0;
			if (c_todo > 0 && int'($urandom_range(99)) < issue_pct)
			begin
				c_ar = make_request(1'b1, c_seq);
				c_seq++;
				c_todo--;
			end
			else
				c_ar = '0;
		end
		c_r_ready = (int'($urandom_range(99)) < c_rdy_pct);
	end

	always @(negedge clk)
	begin
		if (mem_r_fired || !mem_r.valid) // An offered beat stays until taken
		begin
			mem_r_fired = 1'b0;
			mem_r = '0;
			if (mem_q.size() > 0 && !mem_hold && int'($urandom_range(99)) < mem_r_pct)
			begin
				mem_r.valid = 1'b1;
				mem_r.data  = expected_word(mem_q[0].addr, mem_beat);
				mem_r.id    = mem_q[0].id;
				mem_r.last  = (mem_beat == int'(mem_q[0].len));
			end
		end
		mem_ar_ready = (int'($urandom_range(99)) < mem_ar_pct);
	end

	//////////////////////////////////////////////////////////////////////
	// Transfer monitor and beat checker
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (rstnn)
		begin
			if (uc_ar.valid && uc_ar_ready)
			begin
				uc_exp.push_back(burst_of(uc_ar));
				uc_fired = 1'b1;
			end
			if (c_ar.valid && c_ar_ready)
			begin
				c_exp.push_back(burst_of(c_ar));
				c_fired = 1'b1;
			end
			if (mem_ar.valid && mem_ar_ready)
			begin
				mem_q.push_back(burst_of(mem_ar));
				mem_ar_count++;
				if (mem_ar.size !== 3'd2)
					report_value("mem_ar.size", mem_ar.size, 2);
				if (mem_ar.burst !== 2'b01)
					report_value("mem_ar.burst", mem_ar.burst, 1);
			end
			if (mem_r.valid && mem_r_ready)
			begin
				mem_r_fired = 1'b1;
				if (mem_r.last)
				begin
					void'(mem_q.pop_front());
					mem_beat = 0;
					mem_done_count++;
					if (mem_one_shot)
					begin
						mem_hold     = 1'b1;
						mem_one_shot = 1'b0;
					end
				end
				else
					mem_beat++;
			end
			if (uc_r.valid && uc_r_ready)
			begin
				if (uc_exp.size() == 0)
					report_failure("uncached requester got a beat with no burst outstanding");
				else
				begin
					check_beat("uc_r", uc_r, uc_exp[0], uc_beat);
					if (uc_beat == int'(uc_exp[0].len))
					begin
						void'(uc_exp.pop_front());
						uc_beat = 0;
					end
					else
						uc_beat++;
				end
			end
			if (c_r.valid && c_r_ready)
			begin
				if (c_exp.size() == 0)
					report_failure("cached requester got a beat with no burst outstanding");
				else
				begin
					check_beat("c_r", c_r, c_exp[0], c_beat);
					if (c_beat == int'(c_exp[0].len))
					begin
						void'(c_exp.pop_front());
						c_beat = 0;
					end
					else
						c_beat++;
				end
			end
			if (hold_check && uc_ar.valid && c_ar_ready)
				report_failure("cached requester granted while uncached valid was still high");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int                      ar_base;
		int                      done_base;
		fetch_bus_pkg::rd_beat_t held;

		void'($urandom(34));
		clk = 1'b0;
		rstnn = 1'b0;
		uc_ar = '0;
		c_ar = '0;
		mem_r = '0;
		uc_r_ready = 1'b0;
		c_r_ready = 1'b0;
		mem_ar_ready = 1'b0;
		{errors, checks, test_num, tests_failed, test_err_base} = '0;
		{uc_todo, c_todo, uc_seq, c_seq, uc_beat, c_beat, mem_beat} = '0;
		{mem_ar_count, mem_done_count} = '0;
		{uc_fired, c_fired, mem_r_fired, mem_hold, mem_one_shot, hold_check} = '0;
		issue_pct = 60;
		uc_rdy_pct = 70;
		c_rdy_pct = 70;
		mem_ar_pct = 100; // Ready high in reset shows the gating
		mem_r_pct = 70;

		for (int i = 0; i < RESET_CYCLES; i++)
		begin
			@(posedge clk);
			check_idle_outputs();
		end
		mem_ar_pct = 0; // Memory idle as reset lifts
		@(negedge clk);
		rstnn = 1'b1;
		@(posedge clk);
		check_idle_outputs();
		end_test("reset state");

		mem_ar_pct = 70;
		uc_todo = SINGLE_BURSTS;
		wait_idle();
		c_todo = SINGLE_BURSTS;
		wait_idle();
		end_test("single-source reads");

		issue_pct = 50;
		{uc_rdy_pct, c_rdy_pct, mem_ar_pct, mem_r_pct} = {32'd60, 32'd60, 32'd60, 32'd60};
		uc_todo = MIXED_BURSTS;
		c_todo = MIXED_BURSTS;
		wait_idle();
		end_test("interleaved traffic");

		// Uncached runs back to back, cached starts waiting behind it
		issue_pct = 100;
		{uc_rdy_pct, c_rdy_pct, mem_ar_pct, mem_r_pct} = {32'd100, 32'd100, 32'd100, 32'd50};
		uc_todo = HOLD_BURSTS;
		repeat (2) @(negedge clk);
		if (!uc_ar.valid)
			report_failure("uncached requester went idle before the cached one started");
		c_todo = HOLD_BURSTS;
		hold_check = 1'b1;
		wait_idle();
		hold_check = 1'b0;
		end_test("grant hold");

		mem_hold = 1'b1;
		mem_r_pct = 100;
		ar_base = mem_ar_count;
		uc_todo = LIMIT_BURSTS;
		while (mem_ar_count - ar_base < 3)
			@(negedge clk);
		repeat (6)
		begin
			@(posedge clk);
			check_blocked();
		end
		@(negedge clk);
		if (mem_ar_count - ar_base != 3)
			report_value("accepted address count", mem_ar_count - ar_base, 3);
		done_base = mem_done_count;
		mem_one_shot = 1'b1;
		mem_hold = 1'b0;
		while (mem_done_count == done_base)
			@(negedge clk);
		while (mem_ar_count - ar_base < 4) // Freed slot takes the waiting address
			@(negedge clk);
		repeat (6)
		begin
			@(posedge clk);
			check_blocked();
		end
		@(negedge clk);
		if (mem_ar_count - ar_base != 4)
			report_value("accepted address count", mem_ar_count - ar_base, 4);
		mem_hold = 1'b0;
		wait_idle();
		end_test("order queue limit");

		uc_rdy_pct = 0;
		uc_todo = 1;
		@(posedge clk);
		while (!uc_r.valid)
			@(posedge clk);
		held = uc_r;
		repeat (5)
		begin
			@(posedge clk);
			if (mem_r_ready !== 1'b0)
				report_value("mem_r_ready", mem_r_ready, 0);
			if (uc_r.valid !== 1'b1)
				report_value("uc_r.valid", uc_r.valid, 1);
			if (uc_r.data !== held.data)
				report_value("uc_r.data", uc_r.data, held.data);
		end
		@(negedge clk);
		uc_rdy_pct = 100;
		wait_idle();
		end_test("requester back-pressure");

		$display("Tests run %0d, failed %0d, beats checked %0d, errors %0d, assertion fails %0d",
			test_num, tests_failed, checks, total_errors(), dut.u_asserts.assert_failures);
		if (total_errors() == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
hw/fetch_cfg_pkg.sv
hw/fetch_bus_pkg.sv
hw/read_arbiter.sv
hw/response_order_queue.sv
hw/fetch_merge_top.sv
bench/fetch_merge_asserts.sv
bench/fetch_merge_tb.sv

//--- Bender.yml
package:
  name: fetch_merge

sources:
  # RTL, packages first
  - files:
      - hw/fetch_cfg_pkg.sv
      - hw/fetch_bus_pkg.sv
      - hw/read_arbiter.sv
      - hw/response_order_queue.sv
      - hw/fetch_merge_top.sv

  # Simulation only
  - target: test
    files:
      - bench/fetch_merge_asserts.sv
      - bench/fetch_merge_tb.sv
